/* rtl/cache_consts.svh */
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// cache geometry
`define CACHE_LINES      128
`define WORDS_PER_BLOCK  8
`define TAG_BITS         5

// backing memory, 64 KB as 2 byte words
`define MEM_WORDS        32768

// cycles from a sampled read request to its data valid pulse
`define MEM_LATENCY      4

// power-up contents of memory: each word is its byte address xor this value
`define MEM_INIT_XOR     16'h5A3C

`endif

/* rtl/cache_pkg.sv */
package cache_pkg;

    typedef logic [15:0] word_t;        // one processor / memory word

    // lookup view of a byte address, used by the tag and data arrays
    typedef struct packed {
        logic [4:0] tag;                // upper address bits kept in the tag array
        logic [6:0] index;              // selects one of the 128 lines
        logic [3:0] offset;             // byte inside the 16 byte block
    } lookup_view_t;

    // fill view of the same address, walks the block one word at a time
    typedef struct packed {
        logic [11:0] block;             // block number in memory
        logic [2:0]  word;              // word inside the block
        logic        byte_sel;          // always 0 for word accesses
    } fill_view_t;

    // one 16 bit byte address, two decodes
    typedef union packed {
        lookup_view_t lookup;
        fill_view_t   fill;
    } cache_addr_t;

    // miss handler state
    typedef enum logic {
        FILL_IDLE = 1'b0,               // no miss in progress
        FILL_BUSY = 1'b1                // fetching words of a block
    } fill_state_t;

endpackage

/* rtl/cache_fill_fsm.sv */
`timescale 1ns/100ps

module cache_fill_fsm (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   miss_detected,     // tag array says the access misses
    input  cache_pkg::cache_addr_t miss_address,      // processor address that missed
    input  logic                   memory_data_valid, // word returning from memory
    output logic                   fsm_busy,          // drives the processor stall
    output logic                   memory_read,
    output logic                   write_data_array,  // store memory_data at fill_address
    output logic                   write_tag_array,   // one cycle, last word has landed
    output cache_pkg::cache_addr_t memory_address,    // next request to memory
    output cache_pkg::cache_addr_t fill_address       // word currently being waited on
);
    import cache_pkg::*;

    fill_state_t state;
    cache_addr_t addr_curr;            // word the FSM is waiting for
    cache_addr_t addr_next;
    cache_addr_t addr_step;            // addr_curr moved on by one word
    cache_addr_t track_addr [3];       // shadows the address in flight in memory
    logic        start_fill;
    logic        accept;
    logic        done;

    assign start_fill = miss_detected & (state == FILL_IDLE);

    // the word at the end of the tracking pipe was requested 4 cycles ago,
    // so it names the data on memory_data this cycle
    assign accept = (state == FILL_BUSY) & memory_data_valid & (track_addr[2] == addr_curr);
    assign done   = accept & (&addr_curr.fill.word);   // word 7, byte offset 14

    always_comb begin
        addr_step           = addr_curr;
        addr_step.fill.word = addr_curr.fill.word + 3'd1;   // stays inside the block
    end

    always_comb begin
        addr_next = addr_curr;                  // hold until the right word returns
        if (start_fill) begin
            addr_next               = miss_address;
            addr_next.lookup.offset = 4'h0;     // align to block start
        end else if (accept & ~done) begin
            addr_next = addr_step;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FILL_IDLE;
        end else if (start_fill) begin
            state <= FILL_BUSY;
        end else if (done) begin
            state <= FILL_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            addr_curr <= '0;
        end else begin
            addr_curr <= addr_next;
        end
    end

    // three stages here plus the addr_curr register give the 4 cycle memory latency
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 3; i++) begin
                track_addr[i] <= '0;
            end
        end else if (state == FILL_BUSY) begin   // frozen while idle
            track_addr[0] <= addr_curr;
            track_addr[1] <= track_addr[0];
            track_addr[2] <= track_addr[1];
        end
    end

    // stall holds through the tag write cycle, the access then hits next cycle
    assign fsm_busy = (state == FILL_BUSY) | miss_detected;

    // a request every cycle of the fill; none once the last word is in
    assign memory_read      = start_fill | ((state == FILL_BUSY) & ~done);
    assign memory_address   = addr_next;
    assign fill_address     = addr_curr;
    assign write_data_array = accept;
    assign write_tag_array  = done;

endmodule

/* rtl/cache_tag_array.sv */
`timescale 1ns/100ps

`include "cache_consts.svh"

module cache_tag_array (
    input  logic                   clk,
    input  logic                   reset,
    input  cache_pkg::cache_addr_t cpu_address,
    input  logic                   cpu_read,
    input  logic                   cpu_write,
    input  logic                   write_tag_array,  // fill done, line becomes valid
    output logic                   miss_detected
);

    logic [`CACHE_LINES-1:0] line_valid;          // one bit per line
    logic [`TAG_BITS-1:0]    line_tag [`CACHE_LINES];
    logic [`TAG_BITS-1:0]    stored_tag;
    logic                    stored_valid;
    logic                    tag_match;
    logic                    access;

    // valid bits are control state, cleared on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            line_valid <= '0;
        end else if (write_tag_array) begin
            line_valid[cpu_address.lookup.index] <= 1'b1;
        end
    end

    // tags hold whatever was last filled
    always_ff @(posedge clk) begin
        if (write_tag_array) begin
            line_tag[cpu_address.lookup.index] <= cpu_address.lookup.tag;
        end
    end

    // indexed line for the current request
    assign stored_tag   = line_tag[cpu_address.lookup.index];
    assign stored_valid = line_valid[cpu_address.lookup.index];

    assign tag_match = stored_valid & (stored_tag == cpu_address.lookup.tag);
    assign access    = cpu_read | cpu_write;          // no request, no miss

    assign miss_detected = access & ~tag_match;

endmodule

/* rtl/cache_data_array.sv */
`timescale 1ns/100ps

`include "cache_consts.svh"

module cache_data_array (
    input  logic                   clk,
    input  cache_pkg::cache_addr_t cpu_address,
    input  cache_pkg::cache_addr_t fill_address,
    input  logic                   write_data_array,  // fill word from memory
    input  cache_pkg::word_t       memory_data,
    input  logic                   cpu_store,         // store hit from the processor
    input  cache_pkg::word_t       cpu_write_data,
    output cache_pkg::word_t       cpu_read_data
);
    import cache_pkg::*;

    word_t      line_words [`CACHE_LINES][`WORDS_PER_BLOCK];   // 1024 words, no reset
    logic [6:0] wr_line;
    logic [2:0] wr_word;
    word_t      wr_data;
    logic       wr_en;

    // pick the write source, a fill and a store hit never overlap
    always_comb begin
        if (write_data_array) begin
            wr_line = fill_address.lookup.index;
            wr_word = fill_address.fill.word;
            wr_data = memory_data;
        end else begin
            wr_line = cpu_address.lookup.index;
            wr_word = cpu_address.fill.word;      // byte bit ignored
            wr_data = cpu_write_data;
        end
    end

    assign wr_en = write_data_array | cpu_store;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            line_words[wr_line][wr_word] <= wr_data;
        end
    end

    // read hit data is available in the request cycle
    assign cpu_read_data = line_words[cpu_address.lookup.index][cpu_address.fill.word];

endmodule

/* rtl/main_memory.sv */
`timescale 1ns/100ps

`include "cache_consts.svh"

module main_memory (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   memory_read,       // sample memory_address this cycle
    input  cache_pkg::cache_addr_t memory_address,
    input  logic                   memory_write,      // write-through from the processor
    input  cache_pkg::cache_addr_t write_address,
    input  cache_pkg::word_t       write_data,
    output cache_pkg::word_t       memory_data,
    output logic                   memory_data_valid
);
    import cache_pkg::*;

    word_t                  mem [`MEM_WORDS];               // word addressed
    logic [`MEM_LATENCY-1:0] pipe_valid;                    // bit 0 is the newest read
    cache_addr_t            pipe_addr [`MEM_LATENCY];
    cache_addr_t            out_addr;
    logic [14:0]            rd_index;
    logic [14:0]            wr_index;

    // known contents at time zero, the testbench rebuilds the same pattern
    initial begin
        for (int i = 0; i < `MEM_WORDS; i++) begin
            mem[i] = word_t'(i << 1) ^ (`MEM_INIT_XOR);
        end
    end

    // only the valid bits reset; addresses just shift along
    always_ff @(posedge clk) begin
        if (reset) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid <= {pipe_valid[`MEM_LATENCY-2:0], memory_read};
        end
    end

    always_ff @(posedge clk) begin
        pipe_addr[0] <= memory_address;
        for (int i = 1; i < `MEM_LATENCY; i++) begin
            pipe_addr[i] <= pipe_addr[i-1];
        end
    end

    assign out_addr = pipe_addr[`MEM_LATENCY-1];

    // block and word number together form the word address
    assign rd_index = {out_addr.fill.block, out_addr.fill.word};
    assign wr_index = {write_address.fill.block, write_address.fill.word};

    // single-cycle write
    always_ff @(posedge clk) begin
        if (memory_write) begin
            mem[wr_index] <= write_data;
        end
    end

    // array is read at the last stage, so a write made meanwhile is seen
    assign memory_data       = mem[rd_index];
    assign memory_data_valid = pipe_valid[`MEM_LATENCY-1];

endmodule

/* rtl/cache_top.sv */
`timescale 1ns/100ps

module cache_top (
    input  logic                   clk,
    input  logic                   reset,
    input  cache_pkg::cache_addr_t cpu_address,
    input  logic                   cpu_read,
    input  logic                   cpu_write,
    input  cache_pkg::word_t       cpu_write_data,
    output cache_pkg::word_t       cpu_read_data,
    output logic                   stall
);
    import cache_pkg::*;

    logic        miss_detected;
    logic        fsm_busy;
    logic        memory_read;
    logic        memory_data_valid;
    logic        write_data_array;
    logic        write_tag_array;
    logic        cpu_store;         // store hit into the cache line
    logic        memory_write;      // write-through into memory
    cache_addr_t memory_address;
    cache_addr_t fill_address;
    word_t       memory_data;

    assign stall = fsm_busy;

    // a store only lands in the cache once the line is present
    assign cpu_store    = cpu_write & ~miss_detected;
    assign memory_write = cpu_write & ~stall;

    cache_tag_array tags0 (
        .clk(clk), .reset(reset),
        .cpu_address(cpu_address), .cpu_read(cpu_read), .cpu_write(cpu_write),
        .write_tag_array(write_tag_array), .miss_detected(miss_detected)
    );

    cache_data_array data0 (
        .clk(clk), .cpu_address(cpu_address), .fill_address(fill_address),
        .write_data_array(write_data_array), .memory_data(memory_data),
        .cpu_store(cpu_store), .cpu_write_data(cpu_write_data),
        .cpu_read_data(cpu_read_data)
    );

    cache_fill_fsm fsm0 (
        .clk(clk), .reset(reset),
        .miss_detected(miss_detected), .miss_address(cpu_address),
        .memory_data_valid(memory_data_valid), .fsm_busy(fsm_busy),
        .memory_read(memory_read), .write_data_array(write_data_array),
        .write_tag_array(write_tag_array), .memory_address(memory_address),
        .fill_address(fill_address)
    );

    main_memory mem0 (
        .clk(clk), .reset(reset),
        .memory_read(memory_read), .memory_address(memory_address),
        .memory_write(memory_write), .write_address(cpu_address),   // same cycle as the hit
        .write_data(cpu_write_data),
        .memory_data(memory_data), .memory_data_valid(memory_data_valid)
    );

endmodule

/* testbench/cache_checker.sv */
`timescale 1ns/100ps

module cache_checker (
    input logic                   clk,
    input logic                   reset,
    input cache_pkg::fill_state_t state,
    input logic                   fsm_busy,
    input logic                   write_tag_array,
    input cache_pkg::cache_addr_t memory_address
);
    import cache_pkg::*;

    int unsigned fail_count = 0;      // failed assertions so far

    // tag write closes a fill, a single pulse
    tag_write_pulse: assert property (@(posedge clk) disable iff (reset)
        write_tag_array |=> !write_tag_array)
    else begin
        $error("write_tag_array high for more than one cycle");
        fail_count = fail_count + 1;
    end

    // the fill was already running in the cycle before the last word landed
    tag_write_in_fill: assert property (@(posedge clk) disable iff (reset)
        write_tag_array |-> $past(state == FILL_BUSY))
    else begin
        $error("write_tag_array pulsed without a fill in progress");
        fail_count = fail_count + 1;
    end

    // requests are whole words
    word_aligned_request: assert property (@(posedge clk) disable iff (reset)
        !memory_address.fill.byte_sel)
    else begin
        $error("memory_address has bit 0 set");
        fail_count = fail_count + 1;
    end

    idle_after_reset: assert property (@(posedge clk) reset |=> !fsm_busy)
    else begin
        $error("fsm_busy high in the cycle after reset");
        fail_count = fail_count + 1;
    end

endmodule

bind cache_fill_fsm cache_checker chk0 (
    .clk(clk), .reset(reset), .state(state), .fsm_busy(fsm_busy),
    .write_tag_array(write_tag_array), .memory_address(memory_address)
);

/* testbench/cache_tb.sv */
`timescale 1ns/100ps

`include "cache_consts.svh"

module cache_tb;
    import cache_pkg::*;

    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 8;
    localparam int RANDOM_ENTRIES = 24;
    localparam int CYCLES_PER_ENTRY = 64;    // watchdog budget, a fill is about 35

    typedef enum logic [1:0] {
        OP_READ,
        OP_WRITE,
        OP_RESET                              // mid-run reset pulse
    } op_t;

    typedef struct packed {
        op_t         op;
        cache_addr_t addr;
        word_t       wdata;
        logic        exp_miss;                // stall expected in the request cycle
        word_t       exp_data;                // only compared on reads
    } entry_t;

    logic        clk;
    logic        reset;
    cache_addr_t cpu_address;
    logic        cpu_read;
    logic        cpu_write;
    word_t       cpu_write_data;
    word_t       cpu_read_data;
    logic        stall;

    entry_t               stim_q [$];
    logic                 model_valid [`CACHE_LINES];    // shadow tag table
    logic [`TAG_BITS-1:0] model_tag [`CACHE_LINES];
    word_t                written_words [logic [15:0]];  // words stored so far
    int                   seed;
    int                   error_count;
    int                   assert_count;
    int                   tests_passed;
    int                   tests_failed;
    logic                 stim_ready;

    cache_top dut0 (
        .clk(clk), .reset(reset),
        .cpu_address(cpu_address), .cpu_read(cpu_read), .cpu_write(cpu_write),
        .cpu_write_data(cpu_write_data),
        .cpu_read_data(cpu_read_data), .stall(stall)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // memory starts as byte address xor pattern, later stores override it
    function automatic word_t expected_word(input cache_addr_t a);
        logic [15:0] key;
        key = a;
        if (written_words.exists(key))
            return written_words[key];
        return word_t'(key) ^ word_t'(`MEM_INIT_XOR);
    endfunction

    task automatic compare_word(input word_t expected, input word_t actual, input string name);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected 0x%04h, got 0x%04h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_stall(input bit expected, input bit actual, input string name);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %0b, got %0b", $time, name, expected, actual);
            error_count++;
        end
    endtask

    // runs the shadow model as entries are queued, so expectations follow program order
    task automatic add_entry(input op_t op, input cache_addr_t a, input word_t wdata);
        entry_t      e;
        logic [15:0] key;
        key        = a;
        e.op       = op;
        e.addr     = a;
        e.wdata    = wdata;
        e.exp_miss = 1'b0;
        e.exp_data = '0;
        if (op == OP_RESET) begin
            for (int i = 0; i < `CACHE_LINES; i++) begin
                model_valid[i] = 1'b0;                 // memory is untouched
            end
        end else begin
            // direct mapped, hit only if the indexed line holds this tag
            e.exp_miss = !(model_valid[a.lookup.index] &&
                           model_tag[a.lookup.index] == a.lookup.tag);
            model_valid[a.lookup.index] = 1'b1;        // miss or not, line now holds it
            model_tag[a.lookup.index]   = a.lookup.tag;
            if (op == OP_WRITE)
                written_words[key] = wdata;
            e.exp_data = expected_word(a);
        end
        stim_q.push_back(e);
    endtask

    task automatic build_table();
        logic [31:0] r;
        cache_addr_t a;
        for (int i = 0; i < `CACHE_LINES; i++) begin
            model_valid[i] = 1'b0;
        end
        // cold miss, then other words of the same block
        add_entry(OP_READ,  16'h1234, '0);
        add_entry(OP_READ,  16'h1230, '0);
        add_entry(OP_READ,  16'h1236, '0);
        add_entry(OP_READ,  16'h123E, '0);
        // write hit, evict with 0x1A34 (same index 0x23), reread from memory
        add_entry(OP_WRITE, 16'h1234, 16'hBEEF);
        add_entry(OP_READ,  16'h1234, '0);
        add_entry(OP_READ,  16'h1A34, '0);
        add_entry(OP_READ,  16'h1234, '0);
        // write miss allocates, neighbours keep the pattern
        add_entry(OP_WRITE, 16'h4A76, 16'hC0DE);
        add_entry(OP_READ,  16'h4A74, '0);
        add_entry(OP_READ,  16'h4A76, '0);
        add_entry(OP_READ,  16'h4A78, '0);
        // two tags on line 0x10, every access misses
        add_entry(OP_READ,  16'h2100, '0);
        add_entry(OP_READ,  16'h3100, '0);
        add_entry(OP_READ,  16'h2102, '0);
        add_entry(OP_READ,  16'h3104, '0);
        // cached before reset, missing after, stored data still in memory
        add_entry(OP_READ,  16'h4A76, '0);
        add_entry(OP_RESET, 16'h0000, '0);
        add_entry(OP_READ,  16'h4A76, '0);
        add_entry(OP_READ,  16'h1234, '0);
        // random mix over 4 lines and 2 tags so hits and conflicts both occur
        for (int i = 0; i < RANDOM_ENTRIES; i++) begin
            r                = $random(seed);
            a.lookup.tag     = r[2] ? 5'h02 : 5'h0B;
            a.lookup.index   = 7'h22 + {5'd0, r[1:0]};
            a.lookup.offset  = {r[5:3], 1'b0};
            add_entry((r[7:6] == 2'b00) ? OP_WRITE : OP_READ, a, r[31:16]);
        end
    endtask

    task automatic apply_entry(input int n, input entry_t e);
        logic  saw_stall;
        word_t got;
        int    errors_before;
        errors_before = error_count;
        if (e.op == OP_RESET) begin
            @(negedge clk);
            reset = 1'b1;
            repeat (2) @(posedge clk);
            @(negedge clk);
            reset = 1'b0;
            $display("entry %2d reset pulse: ok", n);
            tests_passed++;
        end else begin
            @(negedge clk);
            cpu_address    = e.addr;
            cpu_read       = (e.op == OP_READ);
            cpu_write      = (e.op == OP_WRITE);
            cpu_write_data = e.wdata;
            @(posedge clk);
            saw_stall = stall;                 // request cycle
            while (stall) begin                // held until a low stall at an edge
                @(posedge clk);
            end
            got = cpu_read_data;               // access completes in this cycle
            @(negedge clk);
            cpu_read  = 1'b0;                  // idle for one cycle
            cpu_write = 1'b0;
            compare_stall(e.exp_miss, saw_stall, "stall");
            if (e.op == OP_READ)
                compare_word(e.exp_data, got, "cpu_read_data");
            if (error_count == errors_before)
                tests_passed++;
            else
                tests_failed++;
            $display("entry %2d %s 0x%04h %s: %s", n, (e.op == OP_READ) ? "read " : "write",
                     e.addr, e.exp_miss ? "miss" : "hit ",
                     (error_count == errors_before) ? "ok" : "error");
        end
    endtask

    initial begin
        reset          = 1'b1;
        cpu_address    = '0;
        cpu_read       = 1'b0;
        cpu_write      = 1'b0;
        cpu_write_data = '0;
        error_count    = 0;
        assert_count   = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        seed           = 56463;
        stim_ready     = 1'b0;
        build_table();
        stim_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        foreach (stim_q[i]) begin
            apply_entry(i, stim_q[i]);
        end
        assert_count = dut0.fsm0.chk0.fail_count;   // fill FSM assertions
        error_count  = error_count + assert_count;
        $display("%0d entries: %0d passed, %0d failed, %0d assertion failures",
                 stim_q.size(), tests_passed, tests_failed, assert_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // a stuck fill keeps stall high forever
    initial begin
        wait (stim_ready);
        #(stim_q.size() * CYCLES_PER_ENTRY * CLK_PERIOD);
        $display("watchdog expired at %0t: the cache never released stall", $time);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* cache.f */
+incdir+rtl
rtl/cache_pkg.sv
rtl/cache_fill_fsm.sv
rtl/cache_tag_array.sv
rtl/cache_data_array.sv
rtl/main_memory.sv
rtl/cache_top.sv
testbench/cache_checker.sv
testbench/cache_tb.sv

/* Makefile */
TOOL       = verilator
TOP        = cache_tb
FILELIST   = cache.f
FLAGS      = --binary --timing --assert --timescale 1ns/100ps
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/100ps -Wall
OBJ_DIR    = obj_dir
RUN_ARGS   = +verilator+error+limit+1000
LOG        = sim.log
FAIL_MSG   = Simulation failed
PASS_MSG   = Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "RESULT: FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "RESULT: run ended early"; exit 1; fi
	@echo "RESULT: PASS"

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
